// ==== src/tft_settings.svh ====
`ifndef TFT_SETTINGS_SVH
`define TFT_SETTINGS_SVH

// hwclk cycles per enable tick
// 10 MHz hwclk over 19 gives roughly a 526 kHz tick rate
`define TFT_DIVIDE_COUNT 32'd19

// ticks per unit of a delay entry payload
`define TFT_DELAY_UNIT 32'd4

// entries in the panel init table
`define TFT_TABLE_LEN 12

// bits per spi transfer
`define TFT_BYTE_BITS 8

// table entry flag positions
`define TFT_CMD_BIT 15
`define TFT_DELAY_BIT 14

`endif

// ==== src/tft_pkg.sv ====
`include "tft_settings.svh"

package tft_pkg;

  // one table entry
  // bit 15 command, bit 14 delay, bits 7:0 payload
  typedef logic [15:0] cmd_word_t;

  // payload byte shifted out on mosi
  typedef logic [`TFT_BYTE_BITS-1:0] spi_byte_t;

  // pointer into init_table
  typedef logic [3:0] table_index_t;

  // pause counter, holds up to 255 * delay unit
  typedef logic [11:0] delay_count_t;

  typedef enum logic [2:0] {
    seq_idle, seq_fetch, seq_request, seq_wait_ack, seq_release, seq_pause, seq_finish
  } seq_state_t;

  typedef enum logic [1:0] {
    spi_idle, spi_low, spi_high, spi_end_ack
  } spi_state_t;

  // panel bring-up, roughly an st7735 style init
  localparam cmd_word_t init_table [`TFT_TABLE_LEN] = '{
    16'h8001,  // software reset
    16'h4005,  // wait after reset
    16'h8011,  // sleep out
    16'h400a,  // wait for wake
    16'h803a,  // pixel format
    16'h0055,  // 16 bits per pixel
    16'h8036,  // memory access control
    16'h0008,  // bgr order
    16'h8013,  // normal display mode
    16'h8029,  // display on
    16'h4002,  // short settle
    16'h802c   // start of ram write
  };

endpackage

// ==== src/spi_tick_divider.sv ====
`timescale 1ns/1ps
`include "tft_settings.svh"

module spi_tick_divider (
  input  logic hwclk,
  input  logic reset,
  output logic tick
);

  // word sized to match the divide count constant
  logic [31:0] count;
  logic        wrap;

  // last cycle of the divider period
  assign wrap = (count == `TFT_DIVIDE_COUNT - 32'd1);

  // free running counter
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (wrap) begin
      count <= '0;
    end else begin
      count <= count + 32'd1;
    end
  end

  // registered pulse, one hwclk wide
  // first one lands divide count cycles after reset drops
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      tick <= 1'b0;
    end else begin
      tick <= wrap;
    end
  end

endmodule

// ==== src/tft_init_sequencer.sv ====
`timescale 1ns/1ps
`include "tft_settings.svh"

module tft_init_sequencer (
  input  logic                hwclk,
  input  logic                reset,
  input  logic                tick,
  input  logic                start,
  input  logic                byte_ack,
  output logic                byte_req,
  output tft_pkg::spi_byte_t  byte_data,
  output logic                byte_is_cmd,
  output logic                busy,
  output logic                done
);

  tft_pkg::seq_state_t   state;
  tft_pkg::table_index_t index;
  tft_pkg::delay_count_t delay_cnt;
  tft_pkg::cmd_word_t    entry;
  logic                  start_d;
  logic                  start_rise;
  logic                  last_entry;
  logic                  can_start;

  // current table word
  assign entry = tft_pkg::init_table[index];

  assign start_rise = start & ~start_d;
  assign last_entry = (index == tft_pkg::table_index_t'(`TFT_TABLE_LEN - 1));

  // start only counts between runs
  assign can_start = (state == tft_pkg::seq_idle) || (state == tft_pkg::seq_finish);

  // edge detect runs every cycle, start may be a single hwclk pulse
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      start_d <= 1'b0;
    end else begin
      start_d <= start;
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state     <= tft_pkg::seq_idle;
      index     <= '0;
      delay_cnt <= '0;
      byte_req  <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else if (can_start && start_rise) begin
      // new run from the top of the table
      state <= tft_pkg::seq_fetch;
      index <= '0;
      busy  <= 1'b1;
      done  <= 1'b0;
    end else if (tick) begin
      case (state)
        tft_pkg::seq_fetch: begin
          if (entry[`TFT_DELAY_BIT]) begin
            // payload scaled to ticks
            delay_cnt <= tft_pkg::delay_count_t'(entry[7:0] * `TFT_DELAY_UNIT);
            state     <= tft_pkg::seq_pause;
          end else begin
            state <= tft_pkg::seq_request;
          end
        end
        tft_pkg::seq_request: begin
          // previous handshake must be fully closed
          if (!byte_ack) begin
            byte_req <= 1'b1;
            state    <= tft_pkg::seq_wait_ack;
          end
        end
        tft_pkg::seq_wait_ack: begin
          // writer holds us here as long as it needs
          if (byte_ack) begin
            byte_req <= 1'b0;
            state    <= tft_pkg::seq_release;
          end
        end
        tft_pkg::seq_release, tft_pkg::seq_pause: begin
          // both end by moving to the next entry
          if ((state == tft_pkg::seq_release && !byte_ack) ||
              (state == tft_pkg::seq_pause && delay_cnt <= 1)) begin
            if (last_entry) begin
              state <= tft_pkg::seq_finish;
              busy  <= 1'b0;
              done  <= 1'b1;
            end else begin
              index <= index + 1'b1;
              state <= tft_pkg::seq_fetch;
            end
          end else if (state == tft_pkg::seq_pause) begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        default: begin
          // idle and finish wait for start above
          state <= state;
        end
      endcase
    end
  end

  // payload for the writer, only loaded in fetch so it holds during req
  always_ff @(posedge hwclk) begin
    if (tick && state == tft_pkg::seq_fetch) begin
      byte_data   <= entry[7:0];
      byte_is_cmd <= entry[`TFT_CMD_BIT];
    end
  end

endmodule

// ==== src/tft_spi_writer.sv ====
`timescale 1ns/1ps
`include "tft_settings.svh"

module tft_spi_writer (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               tick,
  input  logic               byte_req,
  input  tft_pkg::spi_byte_t byte_data,
  input  logic               byte_is_cmd,
  output logic               byte_ack,
  output logic               sclk,
  output logic               mosi,
  output logic               cs_n,
  output logic               dc
);

  localparam int BIT_CNT_W = $clog2(`TFT_BYTE_BITS);

  tft_pkg::spi_state_t  state;
  tft_pkg::spi_byte_t   shift;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 load;
  logic                 next_bit;
  logic                 last_bit;

  // new request, only once the old ack is gone
  assign load = tick && (state == tft_pkg::spi_idle) && byte_req && !byte_ack;

  // falling sclk edge that moves on to another bit
  assign last_bit = (bit_cnt == BIT_CNT_W'(`TFT_BYTE_BITS - 1));
  assign next_bit = tick && (state == tft_pkg::spi_high) && !last_bit;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state    <= tft_pkg::spi_idle;
      bit_cnt  <= '0;
      byte_ack <= 1'b0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      cs_n     <= 1'b1;
      dc       <= 1'b0;
    end else begin
      case (state)
        tft_pkg::spi_idle: begin
          if (load) begin
            // select panel, dc low for commands
            cs_n    <= 1'b0;
            dc      <= ~byte_is_cmd;
            // msb goes out first
            mosi    <= byte_data[`TFT_BYTE_BITS-1];
            sclk    <= 1'b0;
            bit_cnt <= '0;
            state   <= tft_pkg::spi_low;
          end
        end
        tft_pkg::spi_low: begin
          // panel samples on this rising edge, mode 0
          if (tick) begin
            sclk  <= 1'b1;
            state <= tft_pkg::spi_high;
          end
        end
        tft_pkg::spi_high: begin
          if (tick) begin
            sclk <= 1'b0;
            if (last_bit) begin
              // byte done, deselect and ack in the same tick
              cs_n     <= 1'b1;
              byte_ack <= 1'b1;
              state    <= tft_pkg::spi_end_ack;
            end else begin
              mosi    <= shift[`TFT_BYTE_BITS-1];
              bit_cnt <= bit_cnt + 1'b1;
              state   <= tft_pkg::spi_low;
            end
          end
        end
        tft_pkg::spi_end_ack: begin
          // close the four phase handshake
          // no tick needed, req drop is already tick aligned
          if (!byte_req) begin
            byte_ack <= 1'b0;
            state    <= tft_pkg::spi_idle;
          end
        end
        default: begin
          state <= tft_pkg::spi_idle;
        end
      endcase
    end
  end

  // remaining bits, msb of shift is the next one out
  always_ff @(posedge hwclk) begin
    if (load) begin
      shift <= byte_data << 1;
    end else if (next_bit) begin
      shift <= shift << 1;
    end
  end

endmodule

// ==== src/tft_panel_top.sv ====
`timescale 1ns/1ps

module tft_panel_top (
  input  logic hwclk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic done,
  output logic sclk,
  output logic mosi,
  output logic cs_n,
  output logic dc
);

  // shared enable, all blocks stay on hwclk
  logic tick;

  // sequencer to writer handshake
  logic               byte_req;
  logic               byte_ack;
  tft_pkg::spi_byte_t byte_data;
  logic               byte_is_cmd;

  spi_tick_divider divider_i (
    .hwclk (hwclk),
    .reset (reset),
    .tick  (tick)
  );

  // walks the init table
  tft_init_sequencer sequencer_i (
    .hwclk       (hwclk),
    .reset       (reset),
    .tick        (tick),
    .start       (start),
    .byte_ack    (byte_ack),
    .byte_req    (byte_req),
    .byte_data   (byte_data),
    .byte_is_cmd (byte_is_cmd),
    .busy        (busy),
    .done        (done)
  );

  // one byte per request onto the panel pins
  tft_spi_writer writer_i (
    .hwclk       (hwclk),
    .reset       (reset),
    .tick        (tick),
    .byte_req    (byte_req),
    .byte_data   (byte_data),
    .byte_is_cmd (byte_is_cmd),
    .byte_ack    (byte_ack),
    .sclk        (sclk),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .dc          (dc)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic hwclk,
  output logic reset
);

  // free running clock, low at time zero
  initial begin
    hwclk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      hwclk = ~hwclk;
    end
  end

  // reset from time zero, released just after a rising edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge hwclk);
    #1;
    reset = 1'b0;
  end

endmodule

// ==== tb/tft_panel_tb.sv ====
`timescale 1ns/1ps
`include "tft_settings.svh"

module tft_panel_tb;

  localparam int PERIOD_NS     = 8;
  localparam int RUN_COUNT     = 5;
  localparam int RUN_TIMEOUT   = 20000;
  // longer than the biggest pause plus one byte
  localparam int BYTE_TIMEOUT  = 2000;
  localparam int RESET_TIMEOUT = 20;

  logic hwclk;
  logic reset;
  logic start;
  logic busy;
  logic done;
  logic sclk;
  logic mosi;
  logic cs_n;
  logic dc;

  // expected stream from the table
  int exp_byte[$];
  int exp_dc[$];
  int exp_gap[$];

  // stream seen on the panel pins over all runs
  int rx_byte[$];
  int rx_dc[$];
  int rx_gap[$];

  logic                      in_byte;
  int                        bit_count;
  logic [`TFT_BYTE_BITS-1:0] shift_in;
  logic                      byte_dc;
  logic                      sclk_q;
  // hwclk cycles of cs_n high since the last byte
  int                        high_cycles;
  logic                      run_active;

  tb_clock_gen #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (3)
  ) clock_gen_i (
    .hwclk (hwclk),
    .reset (reset)
  );

  tft_panel_top tft_panel_top_i (
    .hwclk (hwclk),
    .reset (reset),
    .start (start),
    .busy  (busy),
    .done  (done),
    .sclk  (sclk),
    .mosi  (mosi),
    .cs_n  (cs_n),
    .dc    (dc)
  );

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input int got, input int want);
    if (got != want) begin
      stop_with_error($sformatf("Mismatch at %0d ns: %s got 0x%0h expected 0x%0h",
                                $time, name, got, want));
    end
  endtask

  // table to byte list with each delay folded into the gap before the next byte
  task automatic build_expected();
    int                 i;
    int                 pending_gap;
    tft_pkg::cmd_word_t word;
    pending_gap = 0;
    for (i = 0; i < `TFT_TABLE_LEN; i++) begin
      word = tft_pkg::init_table[i];
      if (word[`TFT_DELAY_BIT]) begin
        pending_gap += int'(word[7:0]) * `TFT_DELAY_UNIT * `TFT_DIVIDE_COUNT;
      end else begin
        exp_byte.push_back(int'(word[7:0]));
        // commands go out with dc low
        exp_dc.push_back(word[`TFT_CMD_BIT] ? 0 : 1);
        exp_gap.push_back(pending_gap);
        pending_gap = 0;
      end
    end
  endtask

  // pins and status sampled on the falling edge away from updates
  always @(negedge hwclk) begin
    if (reset !== 1'b0) begin
      in_byte     = 1'b0;
      bit_count   = 0;
      shift_in    = '0;
      byte_dc     = 1'b0;
      high_cycles = 0;
    end else begin
      // select fell so a new byte starts
      if (!cs_n && !in_byte) begin
        in_byte   = 1'b1;
        bit_count = 0;
        shift_in  = '0;
        rx_gap.push_back(high_cycles);
      end
      // mode 0 where the panel samples on the sclk rise
      if (sclk && !sclk_q) begin
        check_value("cs_n at sclk rise", int'(cs_n), 0);
        if (bit_count == 0) begin
          byte_dc = dc;
        end else begin
          check_value("dc within byte", int'(dc), int'(byte_dc));
        end
        shift_in = {shift_in[`TFT_BYTE_BITS-2:0], mosi};
        bit_count++;
      end
      // select rose so the byte is complete
      if (cs_n && in_byte) begin
        in_byte = 1'b0;
        check_value("sclk rises per byte", bit_count, `TFT_BYTE_BITS);
        rx_byte.push_back(int'(shift_in));
        rx_dc.push_back(int'(byte_dc));
        high_cycles = 0;
      end
      if (cs_n) begin
        high_cycles++;
      end
      // busy holds for the whole run and drops with done
      if (run_active && !done) begin
        check_value("busy during run", int'(busy), 1);
      end
      if (done) begin
        check_value("busy with done", int'(busy), 0);
      end
    end
    sclk_q = sclk;
  end

  task automatic do_run(input int run_no);
    int idle;
    int cycles;
    int since_byte;
    int seen;
    int base;
    int i;
    base = run_no * exp_byte.size();
    idle = $urandom_range(2, 40);
    repeat (idle) begin
      @(posedge hwclk);
      #1;
    end
    // nothing may leak out between runs
    check_value("bytes between runs", rx_byte.size(), base);
    check_value("cs_n between runs", int'(cs_n), 1);
    start = 1'b1;
    @(posedge hwclk);
    #1;
    start = 1'b0;
    check_value("busy after start", int'(busy), 1);
    check_value("done after start", int'(done), 0);
    run_active = 1'b1;
    cycles     = 0;
    since_byte = 0;
    seen       = base;
    while (!done) begin
      @(posedge hwclk);
      #1;
      // stray start pulses that the DUT ignores while busy
      start = ($urandom_range(0, 31) == 0) && !done;
      cycles++;
      if (rx_byte.size() != seen) begin
        seen       = rx_byte.size();
        since_byte = 0;
      end else begin
        since_byte++;
      end
      if (cycles > RUN_TIMEOUT) begin
        stop_with_error($sformatf("Timeout: run %0d never raised done", run_no));
      end
      if (since_byte > BYTE_TIMEOUT) begin
        stop_with_error($sformatf("Timeout: run %0d stalled after %0d bytes", run_no,
                                  seen - base));
      end
    end
    start      = 1'b0;
    run_active = 1'b0;
    check_value("byte count", rx_byte.size(), base + exp_byte.size());
    for (i = 0; i < exp_byte.size(); i++) begin
      check_value($sformatf("byte %0d data", i), rx_byte[base + i], exp_byte[i]);
      check_value($sformatf("byte %0d dc", i), rx_dc[base + i], exp_dc[i]);
      // lower bound only where a delay entry comes before the byte
      if (exp_gap[i] > 0) begin
        check_value($sformatf("byte %0d cs_n high cycles", i),
                    (rx_gap[base + i] < exp_gap[i]) ? rx_gap[base + i] : exp_gap[i],
                    exp_gap[i]);
      end
    end
    check_value("cs_n after done", int'(cs_n), 1);
    check_value("sclk after done", int'(sclk), 0);
  endtask

  initial begin
    int waited;
    int run;
    start      = 1'b0;
    run_active = 1'b0;
    void'($urandom(57));
    build_expected();
    waited = 0;
    while (reset !== 1'b0) begin
      @(posedge hwclk);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        stop_with_error("reset was never released");
      end
    end
    #1;
    // quiet panel before the first start
    repeat ($urandom_range(5, 60)) begin
      @(posedge hwclk);
      #1;
    end
    check_value("cs_n before start", int'(cs_n), 1);
    check_value("sclk before start", int'(sclk), 0);
    check_value("done before start", int'(done), 0);
    check_value("busy before start", int'(busy), 0);
    check_value("bytes before start", rx_byte.size(), 0);
    for (run = 0; run < RUN_COUNT; run++) begin
      do_run(run);
    end
    $display("sim passed");
    $finish;
  end

endmodule

// ==== tft_panel_top.f ====
+incdir+src
src/tft_pkg.sv
src/spi_tick_divider.sv
src/tft_init_sequencer.sv
src/tft_spi_writer.sv
src/tft_panel_top.sv
tb/tb_clock_gen.sv
tb/tft_panel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tft panel testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

# compile, then run, all output into one log
verilator --binary --timing --top-module tft_panel_tb -f tft_panel_top.f \
  -o tft_panel_sim > "$LOG" 2>&1 \
  && ./obj_dir/tft_panel_sim >> "$LOG" 2>&1

cat "$LOG"

# a failed build leaves no pass line either
grep -q "sim failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "sim passed" "$LOG" || { echo "FAIL: no pass line in $LOG"; exit 1; }
echo "PASS"
